// File: include/mem_bridge_params.svh
`ifndef MEM_BRIDGE_PARAMS_SVH
`define MEM_BRIDGE_PARAMS_SVH

// Core and AXI bus widths
`define BUS_W 32
`define STRB_W 4

// Data memory word address
`define DMEM_ADDR_W 13

// Address map
`define AXI_BASE 32'h8000_0000
`define IMEM_BASE 32'h2000_0000
`define IMEM_LIMIT 32'h4000_0000
`define DMEM_BASE 32'h0000_0000

`endif

// File: hdl/mem_bridge_pkg.sv
package mem_bridge_pkg;

    // Where a captured request is sent
    typedef enum logic [1:0] {
        TGT_DMEM,
        TGT_IMEM,
        TGT_AXI
    } target_t;

    typedef enum logic [2:0] {
        AXI_IDLE,
        AXI_RD_ADDR,
        AXI_RD_DATA,
        AXI_WR_BOTH,
        AXI_WR_ADDR,
        AXI_WR_DATA
    } axi_state_t;

    // Data memory has one cycle of read latency
    typedef enum logic {
        BRAM_IDLE,
        BRAM_RD_WAIT
    } bram_state_t;

endpackage

// File: hdl/bridge_req_if.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

interface bridge_req_if;
    import mem_bridge_pkg::*;

    // One cycle pulse, the fields below stay stable until the next request
    logic start;
    target_t target;
    logic is_write;
    logic [`BUS_W-1:0] addr;
    logic [`BUS_W-1:0] wdata;
    logic [`STRB_W-1:0] wmask;

    modport source (
        output start,
        output target,
        output is_write,
        output addr,
        output wdata,
        output wmask
    );

    modport sink (
        input start,
        input target,
        input is_write,
        input addr,
        input wdata,
        input wmask
    );

endinterface

// File: hdl/req_decoder.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module req_decoder (
    input  logic clk_g,
    input  logic rst_g,
    input  logic rd_valid_in,
    input  logic [`BUS_W-1:0] rd_addr,
    input  logic [`BUS_W-1:0] wr_addr,
    input  logic [`BUS_W-1:0] wr_data,
    input  logic [`STRB_W-1:0] wr_mask,
    input  logic ports_busy,
    output logic ready,
    bridge_req_if.source req
);
    import mem_bridge_pkg::*;

    logic accept;
    logic [`BUS_W-1:0] sel_addr;
    logic [`BUS_W-1:0] local_addr;
    target_t sel_target;

    assign accept = ready && (rd_valid_in || (wr_mask != '0));

    // Reads win over a write in the same cycle
    assign sel_addr = rd_valid_in ? rd_addr : wr_addr;

    always_comb begin
        if (sel_addr >= `AXI_BASE) begin
            sel_target = TGT_AXI;
            local_addr = sel_addr - `AXI_BASE;
        end else if (!rd_valid_in && (sel_addr >= `IMEM_BASE) && (sel_addr < `IMEM_LIMIT)) begin
            sel_target = TGT_IMEM;
            local_addr = (sel_addr - `IMEM_BASE) >> 2;
        end else begin
            // Instruction memory is write only, so reads fall through to data memory
            sel_target = TGT_DMEM;
            local_addr = (sel_addr - `DMEM_BASE) >> 2;
        end
    end

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            req.start <= 1'b0;
            req.target <= TGT_DMEM;
            req.is_write <= 1'b0;
        end else begin
            req.start <= accept;
            if (accept) begin
                req.target <= sel_target;
                req.is_write <= !rd_valid_in;
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (accept) begin
            req.addr <= local_addr;
            req.wdata <= wr_data;
            req.wmask <= wr_mask;
        end
    end

    // Low from the captured cycle until a port stage finishes
    assign ready = !req.start && !ports_busy;

endmodule

// File: hdl/bram_port.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module bram_port (
    input  logic clk_g,
    input  logic rst_g,
    bridge_req_if.sink req,
    input  logic [`BUS_W-1:0] dmem_dout,
    output logic [`DMEM_ADDR_W-1:0] dmem_addr,
    output logic [`BUS_W-1:0] dmem_din,
    output logic dmem_en,
    output logic [`STRB_W-1:0] dmem_we,
    output logic [`BUS_W-1:0] imem_addr,
    output logic [`BUS_W-1:0] imem_din,
    output logic imem_en,
    output logic [`STRB_W-1:0] imem_we,
    output logic bram_rd_valid,
    output logic busy
);
    import mem_bridge_pkg::*;

    bram_state_t state;
    logic dmem_hit;
    logic imem_hit;

    assign dmem_hit = req.start && (req.target == TGT_DMEM);
    assign imem_hit = req.start && (req.target == TGT_IMEM);

    // Both memories see the captured word index and data
    assign dmem_addr = req.addr[`DMEM_ADDR_W-1:0];
    assign dmem_din = req.wdata;
    assign imem_addr = req.addr;
    assign imem_din = req.wdata;

    assign dmem_en = dmem_hit;
    assign dmem_we = (dmem_hit && req.is_write) ? req.wmask : '0;
    assign imem_en = imem_hit;
    assign imem_we = (imem_hit && req.is_write) ? req.wmask : '0;

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            state <= BRAM_IDLE;
        end else begin
            case (state)
                BRAM_IDLE: begin
                    if (dmem_hit && !req.is_write)
                        state <= BRAM_RD_WAIT;
                end
                default: state <= BRAM_IDLE;
            endcase
        end
    end

    // dmem_dout is valid in the wait cycle
    assign bram_rd_valid = (state == BRAM_RD_WAIT);
    assign busy = (state == BRAM_RD_WAIT);

endmodule

// File: hdl/axi_lite_master.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module axi_lite_master (
    input  logic clk_g,
    input  logic rst_g,
    bridge_req_if.sink req,
    output logic [`BUS_W-1:0] araddr,
    output logic arvalid,
    input  logic arready,
    input  logic [`BUS_W-1:0] rdata,
    input  logic rvalid,
    output logic rready,
    output logic [`BUS_W-1:0] awaddr,
    output logic awvalid,
    input  logic awready,
    output logic [`BUS_W-1:0] wdata,
    output logic [`STRB_W-1:0] wstrb,
    output logic wvalid,
    input  logic wready,
    // Write responses are accepted and dropped
    input  logic bvalid,
    output logic bready,
    output logic axi_rd_valid,
    output logic busy
);
    import mem_bridge_pkg::*;

    axi_state_t state;
    axi_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            AXI_IDLE: begin
                if (req.start && (req.target == TGT_AXI))
                    state_nxt = req.is_write ? AXI_WR_BOTH : AXI_RD_ADDR;
            end
            AXI_RD_ADDR: begin
                if (arready)
                    state_nxt = AXI_RD_DATA;
            end
            AXI_RD_DATA: begin
                if (rvalid)
                    state_nxt = AXI_IDLE;
            end
            AXI_WR_BOTH: begin
                // Slaves may take address and data in either order
                if (awready && wready)
                    state_nxt = AXI_IDLE;
                else if (awready)
                    state_nxt = AXI_WR_DATA;
                else if (wready)
                    state_nxt = AXI_WR_ADDR;
            end
            AXI_WR_ADDR: begin
                if (awready)
                    state_nxt = AXI_IDLE;
            end
            AXI_WR_DATA: begin
                if (wready)
                    state_nxt = AXI_IDLE;
            end
            default: state_nxt = AXI_IDLE;
        endcase
    end

    always_ff @(posedge clk_g) begin
        if (rst_g)
            state <= AXI_IDLE;
        else
            state <= state_nxt;
    end

    // Valids come straight from the state, so they hold until accepted
    assign arvalid = (state == AXI_RD_ADDR);
    assign rready = (state == AXI_RD_DATA);
    assign awvalid = (state == AXI_WR_BOTH) || (state == AXI_WR_ADDR);
    assign wvalid = (state == AXI_WR_BOTH) || (state == AXI_WR_DATA);

    assign araddr = req.addr;
    assign awaddr = req.addr;
    assign wdata = req.wdata;
    assign wstrb = wvalid ? req.wmask : '0;

    assign bready = 1'b1;

    assign axi_rd_valid = rready && rvalid;
    assign busy = (state != AXI_IDLE);

endmodule

// File: hdl/mem_bridge_top.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module mem_bridge_top (
    input  logic clk_g,
    input  logic rst_g,
    // Core side
    input  logic rd_valid_in,
    input  logic [`BUS_W-1:0] rd_addr,
    input  logic [`BUS_W-1:0] wr_addr,
    input  logic [`BUS_W-1:0] wr_data,
    input  logic [`STRB_W-1:0] wr_mask,
    output logic ready,
    output logic [`BUS_W-1:0] rd_data,
    output logic rd_valid,
    // Data and instruction memory
    output logic [`DMEM_ADDR_W-1:0] dmem_addr,
    output logic [`BUS_W-1:0] dmem_din,
    input  logic [`BUS_W-1:0] dmem_dout,
    output logic dmem_en,
    output logic [`STRB_W-1:0] dmem_we,
    output logic [`BUS_W-1:0] imem_addr,
    output logic [`BUS_W-1:0] imem_din,
    output logic imem_en,
    output logic [`STRB_W-1:0] imem_we,
    // AXI4-Lite master
    output logic [`BUS_W-1:0] araddr,
    output logic arvalid,
    input  logic arready,
    input  logic [`BUS_W-1:0] rdata,
    input  logic rvalid,
    output logic rready,
    output logic [`BUS_W-1:0] awaddr,
    output logic awvalid,
    input  logic awready,
    output logic [`BUS_W-1:0] wdata,
    output logic [`STRB_W-1:0] wstrb,
    output logic wvalid,
    input  logic wready,
    input  logic bvalid,
    output logic bready
);

    logic ports_busy;
    logic bram_busy;
    logic axi_busy;
    logic bram_rd_valid;
    logic axi_rd_valid;

    bridge_req_if req_bus ();

    req_decoder decoder_i (
        .clk_g(clk_g), .rst_g(rst_g),
        .rd_valid_in(rd_valid_in), .rd_addr(rd_addr),
        .wr_addr(wr_addr), .wr_data(wr_data), .wr_mask(wr_mask),
        .ports_busy(ports_busy), .ready(ready), .req(req_bus.source)
    );

    bram_port bram_i (
        .clk_g(clk_g), .rst_g(rst_g), .req(req_bus.sink), .dmem_dout(dmem_dout),
        .dmem_addr(dmem_addr), .dmem_din(dmem_din), .dmem_en(dmem_en), .dmem_we(dmem_we),
        .imem_addr(imem_addr), .imem_din(imem_din), .imem_en(imem_en), .imem_we(imem_we),
        .bram_rd_valid(bram_rd_valid), .busy(bram_busy)
    );

    axi_lite_master axi_i (
        .clk_g(clk_g), .rst_g(rst_g), .req(req_bus.sink),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .axi_rd_valid(axi_rd_valid), .busy(axi_busy)
    );

    assign ports_busy = bram_busy || axi_busy;

    // Only one access is ever in flight, so the valids never overlap
    assign rd_data = axi_rd_valid ? rdata : dmem_dout;
    assign rd_valid = bram_rd_valid || axi_rd_valid;

endmodule

// File: verif/mem_bridge_assertions.sv
`timescale 1ns/1ps

module mem_bridge_assertions (
    input logic clk_g,
    input logic rst_g,
    input logic arvalid,
    input logic arready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic dmem_en,
    input logic imem_en,
    input logic rd_valid,
    input logic ready
);

    // AXI valids hold until accepted
    ar_hold: assert property (@(posedge clk_g) disable iff (rst_g)
        arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
    aw_hold: assert property (@(posedge clk_g) disable iff (rst_g)
        awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
    w_hold: assert property (@(posedge clk_g) disable iff (rst_g)
        wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");

    one_mem: assert property (@(posedge clk_g) disable iff (rst_g)
        !(dmem_en && imem_en)) else $error("both memory enables high");

    rd_busy: assert property (@(posedge clk_g) disable iff (rst_g)
        rd_valid |-> !ready) else $error("rd_valid while ready is high");

endmodule

bind mem_bridge_top mem_bridge_assertions asrt_i (.*);

// File: verif/mem_bridge_tb.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module mem_bridge_tb;
    import mem_bridge_pkg::*;

    logic clk_g = 1'b0;
    logic rst_g;
    logic rd_valid_in, ready, rd_valid;
    logic [31:0] rd_addr, wr_addr, wr_data, rd_data;
    logic [3:0] wr_mask;
    logic [12:0] dmem_addr;
    logic [31:0] dmem_din, dmem_dout, imem_addr, imem_din;
    logic dmem_en, imem_en;
    logic [3:0] dmem_we, imem_we, wstrb;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready, bvalid, bready;

    logic [31:0] dmem_model [0:8191];
    logic [31:0] ref_dmem [0:8191];
    logic [31:0] axi_mem [0:255];
    logic [31:0] ref_axi [0:255];
    logic [31:0] aw_addr_q, ar_addr_q, w_data_q;
    logic [3:0] w_strb_q;
    logic got_aw, got_w, r_pend;
    int unsigned ar_dly, aw_dly, w_dly, r_dly;

    // Expected request, set by the access task
    logic [31:0] exp_local, exp_data, exp_rdata;
    logic [3:0] exp_we;
    int dmem_en_n, imem_en_n, aw_n, w_n, ar_n, rv_n;
    int errors = 0;
    int tests = 0;
    int cycles = 0;

    mem_bridge_top dut_i (.*);

    always #10 clk_g = ~clk_g;

    always @(posedge clk_g) begin
        cycles++;
        // About 120 accesses at up to 15 cycles each
        if (cycles >= 4000) begin
            $display("Timeout: run did not end within 4000 cycles");
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] m);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (m[b])
                res[b*8 +: 8] = nw[b*8 +: 8];
        return res;
    endfunction

    function automatic logic [31:0] fill_word(input int unsigned a, input logic [31:0] salt);
        return (a * 32'h9E37_79B1) ^ (a << 16) ^ salt;
    endfunction

    // Address map: AXI at the top, write-only IMEM window, DMEM for the rest
    function automatic void expected_route(input logic [31:0] a, input logic wr,
                                           output target_t t, output logic [31:0] loc);
        if (a >= `AXI_BASE) begin
            t = TGT_AXI;
            loc = a - `AXI_BASE;
        end else if (wr && a >= `IMEM_BASE && a < `IMEM_LIMIT) begin
            t = TGT_IMEM;
            loc = (a - `IMEM_BASE) >> 2;
        end else begin
            t = TGT_DMEM;
            loc = (a - `DMEM_BASE) >> 2;
        end
    endfunction

    task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Error %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Failure: %s", msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s done with %0d errors", tests, name, errors - errs_before);
    endtask

    // Data memory with one cycle read latency
    always @(posedge clk_g) begin
        if (dmem_en) begin
            dmem_dout <= dmem_model[dmem_addr];
            dmem_model[dmem_addr] <= merge_bytes(dmem_model[dmem_addr], dmem_din, dmem_we);
        end
    end

    // AXI-Lite slave with random ready and response delays
    always @(posedge clk_g) begin
        if (arvalid && arready) begin
            arready <= 1'b0;
            ar_dly <= $urandom % 5;
            r_dly <= $urandom % 5;
            r_pend <= 1'b1;
            ar_addr_q <= araddr;
        end else if (arvalid) begin
            if (ar_dly == 0)
                arready <= 1'b1;
            else
                ar_dly <= ar_dly - 1;
        end
        if (rvalid && rready) begin
            rvalid <= 1'b0;
        end else if (r_pend && !(arvalid && arready)) begin
            if (r_dly == 0) begin
                rvalid <= 1'b1;
                rdata <= axi_mem[ar_addr_q[9:2]];
                r_pend <= 1'b0;
            end else begin
                r_dly <= r_dly - 1;
            end
        end
        if (awvalid && awready) begin
            awready <= 1'b0;
            aw_dly <= $urandom % 5;
            got_aw <= 1'b1;
            aw_addr_q <= awaddr;
        end else if (awvalid) begin
            if (aw_dly == 0)
                awready <= 1'b1;
            else
                aw_dly <= aw_dly - 1;
        end
        if (wvalid && wready) begin
            wready <= 1'b0;
            w_dly <= $urandom % 5;
            got_w <= 1'b1;
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end else if (wvalid) begin
            if (w_dly == 0)
                wready <= 1'b1;
            else
                w_dly <= w_dly - 1;
        end
        if (got_aw && got_w) begin
            axi_mem[aw_addr_q[9:2]] <= merge_bytes(axi_mem[aw_addr_q[9:2]], w_data_q, w_strb_q);
            got_aw <= 1'b0;
            got_w <= 1'b0;
        end
    end

    // Compare every port event with the expected request
    always @(negedge clk_g) begin
        if (!rst_g) begin
            if (dmem_en) begin
                dmem_en_n++;
                if (dmem_addr != exp_local[12:0])
                    report_value("dmem_addr", dmem_addr, exp_local[12:0]);
                if (dmem_we != exp_we)
                    report_value("dmem_we", dmem_we, exp_we);
                if (exp_we != 0 && dmem_din != exp_data)
                    report_value("dmem_din", dmem_din, exp_data);
            end
            if (imem_en) begin
                imem_en_n++;
                if (imem_addr != exp_local)
                    report_value("imem_addr", imem_addr, exp_local);
                if (imem_we != exp_we)
                    report_value("imem_we", imem_we, exp_we);
                if (imem_din != exp_data)
                    report_value("imem_din", imem_din, exp_data);
            end
            if (awvalid && awready) begin
                aw_n++;
                if (awaddr != exp_local)
                    report_value("awaddr", awaddr, exp_local);
            end
            if (wvalid && wready) begin
                w_n++;
                if (wdata != exp_data)
                    report_value("wdata", wdata, exp_data);
                if (wstrb != exp_we)
                    report_value("wstrb", wstrb, exp_we);
            end
            if (arvalid && arready) begin
                ar_n++;
                if (araddr != exp_local)
                    report_value("araddr", araddr, exp_local);
            end
            if (rd_valid) begin
                rv_n++;
                if (rd_data != exp_rdata)
                    report_value("rd_data", rd_data, exp_rdata);
            end
        end
    end

    task automatic do_access(input logic rd, input logic [31:0] raddr, input logic [31:0] waddr,
                             input logic [31:0] data, input logic [3:0] mask);
        target_t t;
        logic [31:0] loc;
        int n;
        int rv_at;
        expected_route(rd ? raddr : waddr, !rd, t, loc);
        @(negedge clk_g);
        while (!ready)
            @(negedge clk_g);
        exp_local = loc;
        exp_data = data;
        exp_we = rd ? 4'h0 : mask;
        if (rd)
            exp_rdata = (t == TGT_AXI) ? ref_axi[loc[9:2]] : ref_dmem[loc[12:0]];
        else if (t == TGT_DMEM)
            ref_dmem[loc[12:0]] = merge_bytes(ref_dmem[loc[12:0]], data, mask);
        else if (t == TGT_AXI)
            ref_axi[loc[9:2]] = merge_bytes(ref_axi[loc[9:2]], data, mask);
        {dmem_en_n, imem_en_n, aw_n, w_n, ar_n, rv_n} = '0;
        @(posedge clk_g);
        rd_valid_in <= rd;
        rd_addr <= raddr;
        wr_addr <= waddr;
        wr_data <= data;
        wr_mask <= mask;
        @(posedge clk_g);
        rd_valid_in <= 1'b0;
        wr_mask <= 4'h0;
        n = 0;
        rv_at = 0;
        do begin
            @(negedge clk_g);
            n++;
            if (rd_valid && rv_at == 0)
                rv_at = n;
        end while (!ready);
        #1;
        if (dmem_en_n != (t == TGT_DMEM) || imem_en_n != (t == TGT_IMEM))
            report_problem("memory enable count does not match the target");
        if (aw_n != (t == TGT_AXI && !rd) || w_n != (t == TGT_AXI && !rd))
            report_problem("AXI write handshake count is not exactly one each");
        if (ar_n != (t == TGT_AXI && rd) || rv_n != rd)
            report_problem("read handshake or read valid count is wrong");
        if (t == TGT_DMEM && rd && (n != 3 || rv_at != 2))
            report_problem("data memory read timing is off");
        if (t != TGT_AXI && !rd && n != 2)
            report_problem("memory write did not return ready in the second cycle");
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] dq[$];
        logic [31:0] aq[$];
        int e0;
        void'($urandom(97931));
        {rd_valid_in, rd_addr, wr_addr, wr_data, wr_mask} = '0;
        {arready, awready, wready, rvalid, bvalid, rdata, dmem_dout} = '0;
        {got_aw, got_w, r_pend, ar_dly, aw_dly, w_dly, r_dly} = '0;
        for (int i = 0; i < 8192; i++) begin
            dmem_model[i] = fill_word(i, 32'h5A5A_0000);
            ref_dmem[i] = fill_word(i, 32'h5A5A_0000);
        end
        for (int i = 0; i < 256; i++) begin
            axi_mem[i] = fill_word(i, 32'hC3A5_0000);
            ref_axi[i] = fill_word(i, 32'hC3A5_0000);
        end
        rst_g = 1'b1;
        repeat (3) @(posedge clk_g);
        rst_g <= 1'b0;

        e0 = errors;
        @(negedge clk_g);
        if (ready !== 1'b1)
            report_problem("ready is not high after reset");
        if (dmem_en || imem_en || arvalid || awvalid || wvalid || rready || rd_valid)
            report_problem("an enable or valid is high after reset");
        if (dmem_we != 0 || imem_we != 0)
            report_problem("a write enable is set after reset");
        // Write responses are always accepted
        if (bready !== 1'b1)
            report_value("bready", bready, 32'h1);
        end_test("reset", e0);

        e0 = errors;
        for (int i = 0; i < 30; i++) begin
            a = ($urandom % 8192) << 2;
            dq.push_back(a);
            do_access(1'b0, 0, a, $urandom, ($urandom % 15) + 1);
        end
        foreach (dq[i])
            do_access(1'b1, dq[i], 0, 0, 4'h0);
        end_test("data memory", e0);

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            a = `IMEM_BASE + (($urandom % 65536) << 2);
            do_access(1'b0, 0, a, $urandom, ($urandom % 15) + 1);
        end
        end_test("instruction memory", e0);

        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            a = `AXI_BASE + (($urandom % 256) << 2);
            aq.push_back(a);
            do_access(1'b0, 0, a, $urandom, ($urandom % 15) + 1);
        end
        end_test("AXI write", e0);

        e0 = errors;
        foreach (aq[i])
            do_access(1'b1, aq[i], 0, 0, 4'h0);
        for (int i = 0; i < 5; i++)
            do_access(1'b1, `AXI_BASE + (($urandom % 256) << 2), 0, 0, 4'h0);
        end_test("AXI read", e0);

        e0 = errors;
        for (int i = 0; i < 5; i++)
            do_access(1'b1, dq[i], `AXI_BASE + (i << 2), $urandom, 4'hf);
        end_test("read priority", e0);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
hdl/mem_bridge_pkg.sv
hdl/bridge_req_if.sv
hdl/req_decoder.sv
hdl/bram_port.sv
hdl/axi_lite_master.sv
hdl/mem_bridge_top.sv
verif/mem_bridge_assertions.sv
verif/mem_bridge_tb.sv

// File: Bender.yml
package:
  name: mem_bridge

sources:
  - include_dirs:
      - include
    files:
      - hdl/mem_bridge_pkg.sv
      - hdl/bridge_req_if.sv
      - hdl/req_decoder.sv
      - hdl/bram_port.sv
      - hdl/axi_lite_master.sv
      - hdl/mem_bridge_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/mem_bridge_assertions.sv
      - verif/mem_bridge_tb.sv
